// ==== hsi_vector_pkg.sv ====
// HSI vector package with component sizes, vector and job types and the opcode set
package hsi_vector_pkg;

    localparam int COMPONENT_WIDTH = 16;        // Bits per signed H, S or I component
    localparam int COMPONENTS_MAX  = 3;         // Components per vector

    // Band count, wide enough to hold COMPONENTS_MAX
    typedef logic [1:0] band_cnt_t;

    // One signed component
    typedef logic signed [COMPONENT_WIDTH-1:0] hsi_comp_t;

    // Packed vector, component 0 in the low bits
    typedef hsi_comp_t [COMPONENTS_MAX-1:0] hsi_vec_t;

    // Operation codes, anything other than OP_CROSS runs as a dot product
    typedef enum logic [3:0] {
        OP_CROSS = 4'd0,                        // Cross product, always three bands
        OP_DOT   = 4'd1                         // Dot product over the first bands
    } vec_op_t;

    // Work item handed from the fetch stage to the ALU
    typedef struct packed {
        hsi_vec_t  a;                           // First operand from in1
        hsi_vec_t  b;                           // Second operand from in2
        vec_op_t   op;                          // Opcode captured at pop
        band_cnt_t bands;                       // Band count, already clipped
    } vec_job_t;

endpackage

// ==== hsi_fifo.sv ====
// First-word-fall-through vector FIFO with full and empty flags
module hsi_fifo #(
    parameter int DEPTH = 16                    // Entries, power of two
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,    // Write request
    input  hsi_vector_pkg::hsi_vec_t  wr_data,  // Vector to store
    output logic                      full,     // No free entry
    input  logic                      rd_en,    // Pop the head
    output hsi_vector_pkg::hsi_vec_t  rd_data,  // Current head
    output logic                      empty     // Nothing stored
);
    import hsi_vector_pkg::*;

    localparam int AW = $clog2(DEPTH);          // Pointer width

    hsi_vec_t        mem [DEPTH];               // Storage array
    logic [AW-1:0]   wr_ptr;                    // Next slot to write
    logic [AW-1:0]   rd_ptr;                    // Slot of the head
    logic [AW:0]     count;                     // Occupancy, 0..DEPTH
    logic            wr_ok;
    logic            rd_ok;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign wr_ok   = wr_en && !full;            // Writes while full are dropped
    assign rd_ok   = rd_en && !empty;           // Reads while empty are dropped
    assign rd_data = mem[rd_ptr];               // Head shown without a read cycle

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps at DEPTH since it is a power of two
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither leave it unchanged
            endcase
        end
    end

endmodule

// ==== hsi_pair_fetch.sv ====
// Fetch stage popping both input FIFOs together into one job with its control
module hsi_pair_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hsi_vector_pkg::hsi_vec_t  a_head,     // Head of in1 FIFO
    input  hsi_vector_pkg::hsi_vec_t  b_head,     // Head of in2 FIFO
    input  logic                      a_empty,
    input  logic                      b_empty,
    output logic                      pop,        // Shared pop for both FIFOs
    input  hsi_vector_pkg::vec_op_t   op,         // Opcode from outside
    input  logic [31:0]               num_bands,  // Raw band count from outside
    output hsi_vector_pkg::vec_job_t  job,        // Registered job
    output logic                      job_valid,
    input  logic                      job_ready
);
    import hsi_vector_pkg::*;

    band_cnt_t bands_clip;                        // Band count clipped to the vector size

    // Counts above the vector size collapse to the full vector
    assign bands_clip = (num_bands > 32'(COMPONENTS_MAX)) ? band_cnt_t'(COMPONENTS_MAX)
                                                          : band_cnt_t'(num_bands);

    // Pop only with data on both sides and room in the job register
    assign pop = !a_empty && !b_empty && (!job_valid || job_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_valid <= 1'b0;
        end else if (pop) begin
            job_valid <= 1'b1;                    // Refill, even in the cycle the ALU takes it
        end else if (job_ready) begin
            job_valid <= 1'b0;                    // Taken with nothing behind it
        end
    end

    // Payload captured with the control of the pop cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            job.a     <= a_head;
            job.b     <= b_head;
            job.op    <= op;
            job.bands <= bands_clip;
        end
    end

endmodule

// ==== hsi_vector_alu.sv ====
// Arithmetic stage for cross product and band-serial dot product, held until pushed
module hsi_vector_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hsi_vector_pkg::vec_job_t  job,        // Job from the fetch stage
    input  logic                      job_valid,
    output logic                      job_ready,
    output hsi_vector_pkg::hsi_vec_t  res,        // Result toward the out FIFO
    output logic                      res_valid,
    input  logic                      out_full    // Out FIFO back-pressure
);
    import hsi_vector_pkg::*;

    hsi_vec_t   a_reg;                            // Operands kept for the dot loop
    hsi_vec_t   b_reg;
    band_cnt_t  bands_reg;                        // Clipped band count of the held job
    band_cnt_t  idx;                              // Next band to accumulate
    logic       computing;                        // Dot loop in progress
    logic       accept;
    logic       push;
    logic       is_cross;
    hsi_vec_t   cross_res;                        // Cross product of the incoming job

    // Signed multiply kept to the component width, sums then wrap naturally
    function automatic hsi_comp_t mul_lo(input hsi_comp_t x, input hsi_comp_t y);
        logic signed [2*COMPONENT_WIDTH-1:0] p;
        p = x * y;
        return p[COMPONENT_WIDTH-1:0];
    endfunction

    assign push      = res_valid && !out_full;
    assign job_ready = !computing && (!res_valid || push);  // Free again in the push cycle
    assign accept    = job_valid && job_ready;
    assign is_cross  = (job.op == OP_CROSS);                // Other codes run as dot

    always_comb begin
        cross_res[0] = mul_lo(job.a[1], job.b[2]) - mul_lo(job.a[2], job.b[1]);
        cross_res[1] = mul_lo(job.a[2], job.b[0]) - mul_lo(job.a[0], job.b[2]);
        cross_res[2] = mul_lo(job.a[0], job.b[1]) - mul_lo(job.a[1], job.b[0]);
    end

    // Control, a new job overrides the push that freed the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            computing <= 1'b0;
            res_valid <= 1'b0;
            idx       <= '0;
        end else if (accept) begin
            if (is_cross || job.bands <= band_cnt_t'(1)) begin
                computing <= 1'b0;
                res_valid <= 1'b1;                // Done one cycle after acceptance
            end else begin
                computing <= 1'b1;
                res_valid <= 1'b0;
                idx       <= band_cnt_t'(1);      // Band 0 folded in at acceptance
            end
        end else if (push) begin
            res_valid <= 1'b0;
        end else if (computing) begin
            idx <= idx + 1'b1;
            if (idx == bands_reg - band_cnt_t'(1)) begin
                computing <= 1'b0;                // Last band this cycle
                res_valid <= 1'b1;
            end
        end
    end

    // Operands and result registers
    always_ff @(posedge clk) begin
        if (accept) begin
            a_reg     <= job.a;
            b_reg     <= job.b;
            bands_reg <= job.bands;
            if (is_cross) begin
                res <= cross_res;
            end else begin
                res[2] <= '0;                     // Dot result only in component 0
                res[1] <= '0;
                res[0] <= (job.bands == '0) ? hsi_comp_t'(0) : mul_lo(job.a[0], job.b[0]);
            end
        end else if (computing) begin
            res[0] <= res[0] + mul_lo(a_reg[idx], b_reg[idx]);  // One band per cycle
        end
    end

endmodule

// ==== hsi_vector_core.sv ====
// HSI vector unit top chaining input FIFOs, fetch stage, ALU and output FIFO
module hsi_vector_core #(
    parameter int FIFO_DEPTH = 16                   // Depth of every FIFO, power of two
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in1_wr_en,
    input  hsi_vector_pkg::hsi_vec_t  in1_data,
    output logic                      in1_full,
    input  logic                      in2_wr_en,
    input  hsi_vector_pkg::hsi_vec_t  in2_data,
    output logic                      in2_full,
    input  hsi_vector_pkg::vec_op_t   op_code,      // Sampled at each pair pop
    input  logic [31:0]               num_bands,    // Sampled at each pair pop
    input  logic                      out_rd_en,
    output hsi_vector_pkg::hsi_vec_t  out_data,
    output logic                      out_empty,
    output logic                      out_full
);
    import hsi_vector_pkg::*;

    hsi_vec_t  in1_head;                            // FIFO heads into the fetch stage
    hsi_vec_t  in2_head;
    logic      in1_empty;
    logic      in2_empty;
    logic      pop;                                 // Common pop of both inputs
    vec_job_t  job;
    logic      job_valid;
    logic      job_ready;
    hsi_vec_t  res;
    logic      res_valid;

    hsi_fifo #(.DEPTH(FIFO_DEPTH)) fifo_in1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (in1_wr_en),
        .wr_data (in1_data),
        .full    (in1_full),
        .rd_en   (pop),
        .rd_data (in1_head),
        .empty   (in1_empty)
    );

    hsi_fifo #(.DEPTH(FIFO_DEPTH)) fifo_in2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (in2_wr_en),
        .wr_data (in2_data),
        .full    (in2_full),
        .rd_en   (pop),
        .rd_data (in2_head),
        .empty   (in2_empty)
    );

    hsi_pair_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_head    (in1_head),
        .b_head    (in2_head),
        .a_empty   (in1_empty),
        .b_empty   (in2_empty),
        .pop       (pop),
        .op        (op_code),
        .num_bands (num_bands),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready)
    );

    hsi_vector_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .res       (res),
        .res_valid (res_valid),
        .out_full  (out_full)                       // Full flag doubles as ALU back-pressure
    );

    hsi_fifo #(.DEPTH(FIFO_DEPTH)) fifo_out (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (res_valid),                       // Push lands only when not full
        .wr_data (res),
        .full    (out_full),
        .rd_en   (out_rd_en),
        .rd_data (out_data),
        .empty   (out_empty)
    );

endmodule

// ==== tb_hsi_vector_core.sv ====
// Testbench for the HSI vector unit, file-driven cases checked in order at the output FIFO
module tb_hsi_vector_core;
    import hsi_vector_pkg::*;

    localparam int FIFO_DEPTH = 16;
    localparam int DLY        = 5;                 // Drive offset after the rising edge
    localparam int TIMEOUT    = 500;               // Cycles allowed per wait

    logic        clk;
    logic        rst_n;
    logic        in1_wr_en;
    hsi_vec_t    in1_data;
    logic        in1_full;
    logic        in2_wr_en;
    hsi_vec_t    in2_data;
    logic        in2_full;
    vec_op_t     op_code;
    logic [31:0] num_bands;
    logic        out_rd_en;
    hsi_vec_t    out_data;
    logic        out_empty;
    logic        out_full;

    logic [3:0]  case_op [$];                      // Columns of vector_cases.txt
    logic [31:0] case_bands [$];
    logic [47:0] case_a [$];
    logic [47:0] case_b [$];
    logic [47:0] case_exp [$];
    logic [47:0] expect_q [$];                     // Results still owed by the DUT
    logic [31:0] rng;
    int          errors;
    int          checks;

    hsi_vector_core #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in1_wr_en (in1_wr_en),
        .in1_data  (in1_data),
        .in1_full  (in1_full),
        .in2_wr_en (in2_wr_en),
        .in2_data  (in2_data),
        .in2_full  (in2_full),
        .op_code   (op_code),
        .num_bands (num_bands),
        .out_rd_en (out_rd_en),
        .out_data  (out_data),
        .out_empty (out_empty),
        .out_full  (out_full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                    // Period 40
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_counts;
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        report_counts();
        $display("Test failures found");
        $finish;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #DLY;
    endtask

    task automatic load_cases;
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op_v;
        logic [31:0] bands_v;
        logic [47:0] a_v;
        logic [47:0] b_v;
        logic [47:0] exp_v;
        fd = $fopen("vector_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open vector_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // Skip comments
                n = $sscanf(line, "%h %h %h %h %h", op_v, bands_v, a_v, b_v, exp_v);
                if (n == 5) begin
                    case_op.push_back(op_v);
                    case_bands.push_back(bands_v);
                    case_a.push_back(a_v);
                    case_b.push_back(b_v);
                    case_exp.push_back(exp_v);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic write_pair(input logic [47:0] a, input logic [47:0] b);
        int n;
        n = 0;
        while (in1_full || in2_full) begin         // Wait for room on both sides
            next_cycle();
            n++;
            if (n > TIMEOUT) abort_run("Input FIFOs stayed full, pair could not be written");
        end
        in1_wr_en = 1'b1;
        in2_wr_en = 1'b1;
        in1_data  = a;
        in2_data  = b;
        next_cycle();
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
    endtask

    // Control must stay put until the fetch stage has popped the pair
    task automatic wait_pair_taken;
        int n;
        n = 0;
        while (!DUT.fifo_in1.empty) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) abort_run("Fetch stage never popped the input pair");
        end
    endtask

    task automatic read_result(input int gap);
        int n;
        n = 0;
        repeat (gap) next_cycle();                 // Random idle gap on the reader side
        while (out_empty) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) abort_run("No result appeared on the output FIFO");
        end
        if (expect_q.size() == 0) begin
            errors++;
            $display("Output FIFO delivered a result that no input pair asked for");
        end else begin
            check_value("out_data", out_data, expect_q.pop_front());
        end
        out_rd_en = 1'b1;
        next_cycle();
        out_rd_en = 1'b0;
    endtask

    task automatic run_backpressure;
        int   cross_idx [$];
        int   idx;
        int   sent;
        int   n;
        logic seen_out_full;
        idx           = 0;
        sent          = 0;
        n             = 0;
        seen_out_full = 1'b0;
        for (int i = 0; i < case_op.size(); i++) begin
            if (case_op[i] == 4'd0) cross_idx.push_back(i);
        end
        if (cross_idx.size() == 0) abort_run("No cross-product case found in vector_cases.txt");
        op_code   = OP_CROSS;                      // Constant control for the whole burst
        num_bands = 32'd3;
        while (!(in1_full && in2_full)) begin
            if (out_full) seen_out_full = 1'b1;
            if (!in1_full && !in2_full) begin
                in1_wr_en = 1'b1;
                in2_wr_en = 1'b1;
                in1_data  = case_a[cross_idx[idx]];
                in2_data  = case_b[cross_idx[idx]];
                expect_q.push_back(case_exp[cross_idx[idx]]);
                idx  = (idx + 1) % cross_idx.size();
                sent++;
            end
            next_cycle();
            in1_wr_en = 1'b0;
            in2_wr_en = 1'b0;
            n++;
            if (n > TIMEOUT) abort_run("Input FIFOs never filled under back-pressure");
        end
        check_value("out_full_first", 48'(seen_out_full), 48'd1);
        check_value("pairs_accepted", 48'(sent), 48'(2 * FIFO_DEPTH + 2));
        in1_wr_en = 1'b1;                          // Write into full FIFOs is dropped
        in2_wr_en = 1'b1;
        in1_data  = 48'hdead_beef_0bad;
        in2_data  = 48'h0bad_beef_dead;
        next_cycle();
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
        check_value("in1_full", 48'(in1_full), 48'd1);
        check_value("in2_full", 48'(in2_full), 48'd1);
        for (int i = 0; i < sent; i++) begin
            rng = xorshift32(rng);
            read_result(int'(rng[1:0]));
        end
        repeat (8) next_cycle();
        check_value("out_empty_drained", 48'(out_empty), 48'd1);
        check_value("in1_full_drained", 48'(in1_full), 48'd0);
    endtask

    initial begin
        rst_n     = 1'b0;
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
        in1_data  = '0;
        in2_data  = '0;
        op_code   = OP_CROSS;
        num_bands = '0;
        out_rd_en = 1'b0;
        rng       = 32'hc7fdbe93;
        errors    = 0;
        checks    = 0;
        load_cases();
        repeat (16) @(posedge clk);
        #DLY rst_n = 1'b1;
        next_cycle();
        check_value("out_empty", 48'(out_empty), 48'd1);   // Idle state after reset
        check_value("in1_full", 48'(in1_full), 48'd0);
        check_value("in2_full", 48'(in2_full), 48'd0);
        check_value("out_full", 48'(out_full), 48'd0);
        fork
            begin
                for (int i = 0; i < case_a.size(); i++) begin
                    op_code   = vec_op_t'(case_op[i]);
                    num_bands = case_bands[i];
                    expect_q.push_back(case_exp[i]);
                    write_pair(case_a[i], case_b[i]);
                    wait_pair_taken();
                end
            end
            begin
                for (int i = 0; i < case_a.size(); i++) begin
                    rng = xorshift32(rng);
                    read_result(int'(rng[1:0]));
                end
            end
        join
        run_backpressure();
        report_counts();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vector_cases.txt ====
# op bands a b expected, all hex, op 0 is cross and any other code is dot
# vectors are c2 c1 c0 with four hex digits per signed 16-bit component
0 00000003 000000000001 000000010000 000100000000
0 00000003 000300020001 000600050004 fffd0006fffd
0 00000003 fffb0007fffe 0009fffc0003 fff30003002b
0 00000003 00faff38012c 03e80096fe70 7748e5806044
0 00000003 7fff7fff7fff 7fff00018000 ffff7fff8002
0 00000003 fffb0007fffe fffb0007fffe 000000000000
1 00000001 000300020001 000600050004 000000000004
1 00000002 000300020001 000600050004 00000000000e
1 00000003 000300020001 000600050004 000000000020
1 00000005 000300020001 000600050004 000000000020
1 00000000 000300020001 000600050004 000000000000
1 ffffffff 000300020001 000600050004 000000000020
1 00000001 fffb0007fffe 0009fffc0003 00000000fffa
1 00000002 fffb0007fffe 0009fffc0003 00000000ffde
1 00000003 fffb0007fffe 0009fffc0003 00000000ffb1
1 00000001 00faff38012c 03e80096fe70 000000002b40
1 00000002 00faff38012c 03e80096fe70 00000000b610
1 00000003 00faff38012c 03e80096fe70 0000000086a0
1 00000002 7fff7fff7fff 7fff00018000 00000000ffff
1 00000003 7fff7fff7fff 7fff00018000 000000000000
# mixed run, control changes with every pair
0 00000000 000300020001 000600050004 fffd0006fffd
1 00000003 fffb0007fffe 0009fffc0003 00000000ffb1
0 00000005 fffb0007fffe 0009fffc0003 fff30003002b
7 00000003 000300020001 000600050004 000000000020
0 00000001 00faff38012c 03e80096fe70 7748e5806044
f 00000002 000300020001 000600050004 00000000000e
0 00000002 7fff7fff7fff 7fff00018000 ffff7fff8002
1 00000002 00faff38012c 03e80096fe70 00000000b610
0 00000003 000000000001 000000010000 000100000000
1 00000001 7fff7fff7fff 7fff00018000 000000008000
1 00000000 7fff7fff7fff 7fff00018000 000000000000

// ==== verilog.f ====
hsi_vector_pkg.sv
hsi_fifo.sv
hsi_pair_fetch.sv
hsi_vector_alu.sv
hsi_vector_core.sv
tb_hsi_vector_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the HSI vector unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f verilog.f --top-module tb_hsi_vector_core -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
